/* uart_pkg.sv */
package uart_pkg;

    // character framing is 8N1, so only the data width is a constant here.
    localparam int data_bits = 8;

    // a single start command kicks off one measurement run.
    localparam logic [7:0] cmd_start = 8'h73;

    // line terminators sent after the hex digits.
    localparam logic [7:0] ascii_cr = 8'h0d;
    localparam logic [7:0] ascii_lf = 8'h0a;

    // bases for the hex digit conversion, upper case letters.
    localparam logic [7:0] ascii_zero = 8'h30;
    localparam logic [7:0] ascii_upper_a = 8'h41;

endpackage

/* ranging_pkg.sv */
package ranging_pkg;

    // width of the accumulated first-echo offsets over one run.
    localparam int result_w = 24;

    // one hex character per nibble of the result.
    localparam int hex_digits = result_w / 4;

    // window position and ping index counters.
    // a window longer than 65535 cycles would need a wider counter.
    localparam int count_w = 16;

endpackage

/* uart_rx.sv */
module uart_rx #(
    parameter int clk_per_bit = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] data,
    output logic       stb,
    output logic       frame_err
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(clk_per_bit);
    localparam int bit_w = $clog2(data_bits);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;
    logic rx_s1;
    logic rx_s2;
    logic [cnt_w-1:0] cnt;
    logic [bit_w-1:0] bit_cnt;
    logic half_bit;
    logic full_bit;

    assign half_bit = (cnt == cnt_w'(clk_per_bit / 2 - 1));
    assign full_bit = (cnt == cnt_w'(clk_per_bit - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            state <= st_idle;
            cnt <= '0;
            bit_cnt <= '0;
            stb <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            stb <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx_s2) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // a low level that does not last to mid-bit is a glitch.
                    if (half_bit) begin
                        cnt <= '0;
                        bit_cnt <= '0;
                        state <= rx_s2 ? st_idle : st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (full_bit) begin
                        cnt <= '0;
                        if (bit_cnt == bit_w'(data_bits - 1)) begin
                            state <= st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (full_bit) begin
                        state <= st_idle;
                        stb <= rx_s2;
                        frame_err <= !rx_s2;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // bits arrive LSB first, so shift in from the top.
    always_ff @(posedge clk) begin
        if (state == st_data && full_bit) begin
            data <= {rx_s2, data[7:1]};
        end
    end

    a_stb_err_excl: assert property (@(posedge clk) disable iff (rst) !(stb && frame_err));

endmodule

/* uart_tx.sv */
module uart_tx #(
    parameter int clk_per_bit = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [7:0] data,
    output logic       tx,
    output logic       busy
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(clk_per_bit);
    localparam int bit_w = $clog2(data_bits + 2);

    logic [cnt_w-1:0] cnt;
    logic [bit_w-1:0] bit_cnt;
    logic [data_bits:0] shreg;
    logic bit_end;

    assign bit_end = busy && (cnt == cnt_w'(clk_per_bit - 1));

    // bit_cnt counts the bits already on the line: start, data, then stop.
    always_ff @(posedge clk) begin
        if (rst) begin
            tx <= 1'b1;
            busy <= 1'b0;
            cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                tx <= 1'b0;
                busy <= 1'b1;
                cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            cnt <= '0;
            if (bit_cnt == bit_w'(data_bits + 1)) begin
                busy <= 1'b0;
            end else begin
                tx <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // the stop bit sits above the data and ones fill in behind it.
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            shreg <= {1'b1, data};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[data_bits:1]};
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

/* burst_gen.sv */
module burst_gen #(
    parameter int burst_len = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic ping_stb,
    output logic burst_out,
    output logic blank
);

    localparam int cnt_w = $clog2(burst_len + 1);

    logic [cnt_w-1:0] cnt;

    assign burst_out = (cnt != '0);

    // blank is computed from the next count so it tracks burst_out exactly
    // while coming straight from a flop.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            blank <= 1'b0;
        end else if (ping_stb) begin
            cnt <= cnt_w'(burst_len);
            blank <= 1'b1;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            blank <= (cnt != cnt_w'(1));
        end else begin
            blank <= 1'b0;
        end
    end

    a_no_ping_in_burst: assert property (
        @(posedge clk) disable iff (rst) ping_stb |-> !burst_out
    );

endmodule

/* echo_timer.sv */
module echo_timer #(
    parameter int ping_period = 256,
    parameter int ping_count  = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [7:0]                        rx_data,
    input  logic                              rx_stb,
    input  logic                              echo,
    input  logic                              blank,
    output logic                              ping_stb,
    output logic                              busy,
    output logic                              done,
    output logic [ranging_pkg::result_w-1:0] result
);
    import uart_pkg::*;
    import ranging_pkg::*;

    logic [count_w-1:0] win_cnt;
    logic [count_w-1:0] ping_cnt;
    logic [count_w-1:0] first_off;
    logic hit;
    logic [result_w-1:0] sum;
    logic [result_w-1:0] add;
    logic echo_s1;
    logic echo_s2;
    logic echo_s3;
    logic blank_d1;
    logic blank_d2;
    logic rise;
    logic win_end;
    logic start_cmd;

    // blank is delayed by the same two stages as the echo so both line up.
    always_ff @(posedge clk) begin
        if (rst) begin
            echo_s1 <= 1'b0;
            echo_s2 <= 1'b0;
            echo_s3 <= 1'b0;
            blank_d1 <= 1'b0;
            blank_d2 <= 1'b0;
        end else begin
            echo_s1 <= echo;
            echo_s2 <= echo_s1;
            echo_s3 <= echo_s2;
            blank_d1 <= blank;
            blank_d2 <= blank_d1;
        end
    end

    assign rise = echo_s2 && !echo_s3 && !blank_d2;
    assign win_end = busy && (win_cnt == count_w'(ping_period - 1));
    assign start_cmd = rx_stb && (rx_data == cmd_start) && !busy;
    assign add = hit ? result_w'(first_off) : '0;
    assign result = sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            ping_stb <= 1'b0;
            done <= 1'b0;
            win_cnt <= '0;
            ping_cnt <= '0;
            hit <= 1'b0;
            sum <= '0;
        end else begin
            ping_stb <= 1'b0;
            done <= 1'b0;
            if (start_cmd) begin
                busy <= 1'b1;
                ping_stb <= 1'b1;
                win_cnt <= '0;
                ping_cnt <= '0;
                hit <= 1'b0;
                sum <= '0;
            end else if (win_end) begin
                // the finished window is folded into the sum as the next one opens.
                sum <= sum + add;
                hit <= 1'b0;
                win_cnt <= '0;
                if (ping_cnt == count_w'(ping_count - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    ping_cnt <= ping_cnt + 1'b1;
                    ping_stb <= 1'b1;
                end
            end else if (busy) begin
                win_cnt <= win_cnt + 1'b1;
                if (rise) begin
                    hit <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && !win_end && rise && !hit) begin
            first_off <= win_cnt;
        end
    end

    a_win_in_range: assert property (
        @(posedge clk) disable iff (rst) win_cnt < count_w'(ping_period)
    );

endmodule

/* hex_dump.sv */
module hex_dump #(
    parameter int clk_per_bit = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              done,
    input  logic [ranging_pkg::result_w-1:0] result,
    output logic                              tx
);
    import uart_pkg::*;
    import ranging_pkg::*;

    localparam int idx_w = $clog2(hex_digits + 2);

    logic [result_w-1:0] val;
    logic [idx_w-1:0] idx;
    logic active;
    logic tx_busy;
    logic tx_start;
    logic [3:0] nib;
    logic [7:0] tx_char;

    // uart_tx raises busy one cycle after start, so no extra guard is needed.
    assign tx_start = active && !tx_busy;
    assign nib = val[result_w-1 -: 4];

    always_comb begin
        if (idx < idx_w'(hex_digits)) begin
            if (nib < 4'd10) begin
                tx_char = ascii_zero + {4'h0, nib};
            end else begin
                tx_char = ascii_upper_a + {4'h0, nib} - 8'd10;
            end
        end else if (idx == idx_w'(hex_digits)) begin
            tx_char = ascii_cr;
        end else begin
            tx_char = ascii_lf;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            idx <= '0;
        end else if (done) begin
            active <= 1'b1;
            idx <= '0;
        end else if (tx_start) begin
            if (idx == idx_w'(hex_digits + 1)) begin
                active <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // the top nibble always holds the next digit to send.
    always_ff @(posedge clk) begin
        if (done) begin
            val <= result;
        end else if (tx_start) begin
            val <= val << 4;
        end
    end

    uart_tx #(
        .clk_per_bit(clk_per_bit)
    ) u_tx (
        .clk(clk),
        .rst(rst),
        .start(tx_start),
        .data(tx_char),
        .tx(tx),
        .busy(tx_busy)
    );

    a_no_done_in_dump: assert property (
        @(posedge clk) disable iff (rst) done |-> !(active || tx_busy)
    );

endmodule

/* ranger_top.sv */
module ranger_top #(
    parameter int clk_per_bit = 16,
    parameter int ping_period = 256,
    parameter int ping_count  = 4,
    parameter int burst_len   = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    input  logic echo,
    output logic tx,
    output logic burst_out,
    output logic busy
);

    logic [7:0] rx_data;
    logic rx_stb;
    logic ping_stb;
    logic blank;
    logic done;
    logic [ranging_pkg::result_w-1:0] result;

    // framing errors simply drop the character, so the strobe is left open.
    uart_rx #(
        .clk_per_bit(clk_per_bit)
    ) u_rx (
        .clk(clk),
        .rst(rst),
        .rx(rx),
        .data(rx_data),
        .stb(rx_stb),
        .frame_err()
    );

    echo_timer #(
        .ping_period(ping_period),
        .ping_count(ping_count)
    ) u_timer (
        .clk(clk),
        .rst(rst),
        .rx_data(rx_data),
        .rx_stb(rx_stb),
        .echo(echo),
        .blank(blank),
        .ping_stb(ping_stb),
        .busy(busy),
        .done(done),
        .result(result)
    );

    burst_gen #(
        .burst_len(burst_len)
    ) u_burst (
        .clk(clk),
        .rst(rst),
        .ping_stb(ping_stb),
        .burst_out(burst_out),
        .blank(blank)
    );

    hex_dump #(
        .clk_per_bit(clk_per_bit)
    ) u_dump (
        .clk(clk),
        .rst(rst),
        .done(done),
        .result(result),
        .tx(tx)
    );

endmodule

/* tb_ranger.sv */
module tb_ranger;
    import uart_pkg::*;
    import ranging_pkg::*;

    localparam int clk_per_bit = 16;
    localparam int ping_period = 256;
    localparam int ping_count = 4;
    localparam int burst_len = 8;
    localparam int char_cycles = 10 * clk_per_bit;
    localparam int run_cycles = 2 * char_cycles + ping_count * ping_period
        + (hex_digits + 2) * char_cycles + 64;
    localparam int watchdog_cycles = 2 * (10 + 7 * run_cycles);

    logic clk = 1'b0;
    logic rst;
    logic rx;
    logic echo;
    logic tx;
    logic burst_out;
    logic busy;

    int errors = 0;
    int runs = 0;
    integer seed = 32'h7fd1_48f5;
    int burst_total = 0;
    int burst_width = 0;
    int win_delay[ping_count];
    int echo_pulses = 1;
    bit extra_cmd = 1'b0;

    always #10 clk = ~clk;

    ranger_top #(
        .clk_per_bit(clk_per_bit),
        .ping_period(ping_period),
        .ping_count(ping_count),
        .burst_len(burst_len)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .rx(rx),
        .echo(echo),
        .tx(tx),
        .burst_out(burst_out),
        .busy(busy)
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    // every burst is measured at its falling edge.
    always @(negedge clk) begin
        if (rst) begin
            burst_width = 0;
        end else if (burst_out) begin
            burst_width = burst_width + 1;
        end else if (burst_width != 0) begin
            burst_total = burst_total + 1;
            if (burst_width != burst_len) begin
                report_mismatch("burst_out width", burst_len, burst_width);
            end
            burst_width = 0;
        end
    end

    function automatic int expected_sum();
        int total;
        int w;
        total = 0;
        for (w = 0; w < ping_count; w++) begin
            // echoes that rise while the burst is on are blanked.
            if (win_delay[w] >= burst_len) begin
                total = total + win_delay[w] + 3;
            end
        end
        return total;
    endfunction

    function automatic int hex_nibble(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return int'(c) - int'("0");
        end else if (c >= "A" && c <= "F") begin
            return int'(c) - int'("A") + 10;
        end
        return -1;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int i;
        @(posedge clk);
        rx <= 1'b0;
        for (i = 0; i < data_bits; i++) begin
            repeat (clk_per_bit) @(posedge clk);
            rx <= b[i];
        end
        repeat (clk_per_bit) @(posedge clk);
        rx <= 1'b1;
        repeat (clk_per_bit) @(posedge clk);
    endtask

    // the echo model answers each burst d cycles after it rises, or not at all when d < 0.
    task automatic drive_echoes();
        int w;
        int p;
        int wait_cnt;
        for (w = 0; w < ping_count; w++) begin
            wait_cnt = 0;
            @(negedge clk);
            while (!burst_out && wait_cnt < 2 * ping_period + 2 * char_cycles) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!burst_out) begin
                report_failure($sformatf("no burst_out pulse for window %0d", w));
                return;
            end
            if (win_delay[w] >= 0) begin
                repeat (win_delay[w]) @(posedge clk);
                echo <= 1'b1;
                repeat (2) @(posedge clk);
                echo <= 1'b0;
                for (p = 1; p < echo_pulses; p++) begin
                    repeat (4) @(posedge clk);
                    echo <= 1'b1;
                    repeat (2) @(posedge clk);
                    echo <= 1'b0;
                end
            end
            @(negedge clk);
            while (burst_out) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic receive_char(output logic [7:0] c, output bit ok);
        int wait_cnt;
        int i;
        ok = 1'b0;
        c = '0;
        wait_cnt = 0;
        @(negedge clk);
        while (tx && wait_cnt < 4 * char_cycles) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (tx !== 1'b0) begin
            report_failure("no start bit on tx");
            return;
        end
        repeat (clk_per_bit / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            report_failure("start bit on tx did not last to mid-bit");
            return;
        end
        for (i = 0; i < data_bits; i++) begin
            repeat (clk_per_bit) @(negedge clk);
            c[i] = tx;
        end
        repeat (clk_per_bit) @(negedge clk);
        if (tx !== 1'b1) begin
            report_failure("missing stop bit on tx");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic read_result(output int value, output bit ok);
        logic [7:0] c;
        bit char_ok;
        int nib;
        int i;
        value = 0;
        ok = 1'b0;
        for (i = 0; i < hex_digits; i++) begin
            receive_char(c, char_ok);
            if (!char_ok) begin
                return;
            end
            nib = hex_nibble(c);
            if (nib < 0) begin
                report_failure($sformatf("character 0x%02h is not an upper-case hex digit", c));
                return;
            end
            value = value * 16 + nib;
        end
        receive_char(c, char_ok);
        if (!char_ok || c !== ascii_cr) begin
            report_mismatch("tx character after the digits", ascii_cr, c);
            return;
        end
        receive_char(c, char_ok);
        if (!char_ok || c !== ascii_lf) begin
            report_mismatch("tx last character", ascii_lf, c);
            return;
        end
        ok = 1'b1;
    endtask

    task automatic run_measure(input string label);
        int expected;
        int got;
        int bursts_before;
        int wait_cnt;
        bit ok;
        expected = expected_sum();
        bursts_before = burst_total;
        runs++;
        fork
            begin
                send_byte(cmd_start);
                if (extra_cmd) begin
                    repeat (100) @(posedge clk);
                    send_byte(cmd_start);
                end
            end
            drive_echoes();
        join
        wait_cnt = 0;
        @(negedge clk);
        while (busy && wait_cnt < 2 * ping_period) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (busy) begin
            report_failure($sformatf("%s: busy did not fall at the end of the run", label));
            return;
        end
        if (tx !== 1'b1) begin
            report_mismatch("tx when busy falls", 1, tx);
        end
        if (burst_total != bursts_before + ping_count) begin
            report_mismatch("burst_out pulse count", ping_count, burst_total - bursts_before);
        end
        read_result(got, ok);
        if (ok && got != expected) begin
            report_mismatch($sformatf("result of %s", label), expected, got);
        end
        repeat (clk_per_bit) @(negedge clk);
        if (busy !== 1'b0) begin
            report_mismatch("busy after the dump", 0, busy);
        end
        // a run that starts after busy falls shows up as extra bursts during the dump.
        if (burst_total != bursts_before + ping_count) begin
            report_mismatch("burst_out pulse count after the dump", ping_count,
                            burst_total - bursts_before);
        end
        $display("%s: expected 0x%06h, received 0x%06h", label, expected, got);
    endtask

    task automatic check_idle_after_reset();
        int i;
        int bursts_before;
        bit seen_busy;
        @(negedge clk);
        if (tx !== 1'b1) begin
            report_mismatch("tx", 1, tx);
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy", 0, busy);
        end
        if (burst_out !== 1'b0) begin
            report_mismatch("burst_out", 0, burst_out);
        end
        bursts_before = burst_total;
        seen_busy = 1'b0;
        send_byte(8'h41);
        for (i = 0; i < ping_count * ping_period; i++) begin
            @(negedge clk);
            if (busy !== 1'b0 && !seen_busy) begin
                report_mismatch("busy after a non-start byte", 0, busy);
                seen_busy = 1'b1;
            end
        end
        if (burst_total != bursts_before) begin
            report_mismatch("burst_out pulses after a non-start byte", 0,
                            burst_total - bursts_before);
        end
    endtask

    task automatic test_fixed_delay();
        int w;
        for (w = 0; w < ping_count; w++) begin
            win_delay[w] = 20;
        end
        echo_pulses = 1;
        extra_cmd = 1'b0;
        run_measure("fixed delay");
    endtask

    task automatic test_missing_and_blanked();
        win_delay[0] = -1;
        win_delay[1] = 3;
        win_delay[2] = 40;
        win_delay[3] = burst_len - 1;
        echo_pulses = 1;
        extra_cmd = 1'b0;
        run_measure("missing and blanked echoes");
    endtask

    task automatic test_multi_edge_and_restart();
        win_delay[0] = 30;
        win_delay[1] = 55;
        win_delay[2] = 12;
        win_delay[3] = 100;
        echo_pulses = 3;
        extra_cmd = 1'b1;
        run_measure("multiple edges with a second start");
    endtask

    task automatic test_random_delays();
        int r;
        int w;
        echo_pulses = 1;
        extra_cmd = 1'b0;
        for (r = 0; r < 3; r++) begin
            for (w = 0; w < ping_count; w++) begin
                win_delay[w] = burst_len
                    + int'($unsigned($random(seed)) % (ping_period - 8 - burst_len + 1));
            end
            run_measure($sformatf("random run %0d", r));
        end
    endtask

    initial begin
        rst = 1'b1;
        rx = 1'b1;
        echo = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        check_idle_after_reset();
        test_fixed_delay();
        test_missing_and_blanked();
        test_multi_edge_and_restart();
        test_random_delays();
        $display("runs: %0d, errors: %0d", runs, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with the tests still running",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* verilog.f */
uart_pkg.sv
ranging_pkg.sv
uart_rx.sv
uart_tx.sv
burst_gen.sv
echo_timer.sv
hex_dump.sv
ranger_top.sv
tb_ranger.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ranger -f verilog.f -o Vtb_ranger
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ranger)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
